// ==== rtl/laser_log_params.svh ====
// Shared width and size macros of the slow data logger
// Pipe word, ADC sample and digital input widths
// Frame length, FIFO depth and reference pin synchronizer length

`ifndef LASER_LOG_PARAMS_SVH
`define LASER_LOG_PARAMS_SVH

// One host pipe word
`define LOG_WORD_W 16

// Words per logged frame
`define LOG_FRAME_WORDS 6

// One ADC sample, two's complement
`define LOG_ADC_W 16

// Digital inputs on the front panel
`define LOG_DIN_W 3

// Default FIFO depth in words, power of two
`define LOG_FIFO_DEPTH 64

// Flops on the reference clock pin
`define LOG_EXT_SYNC 4

`endif

// ==== rtl/laser_log_pkg.sv ====
// Types of the slow data logger
// ADC sample pair, FIFO write port and the frame layout

`include "laser_log_params.svh"

package laser_log_pkg;

	// Both ADC channels, sampled together
	typedef struct packed {
		logic signed [`LOG_ADC_W-1:0] adc0;
		logic signed [`LOG_ADC_W-1:0] adc1;
	} adc_sample_t;

	// Single word write into the FIFO
	typedef struct packed {
		logic                   wr;   // Write strobe
		logic [`LOG_WORD_W-1:0] data; // Word to store
	} fifo_wr_t;

	// Status word, skipped tick count above the inputs
	typedef struct packed {
		logic [`LOG_WORD_W-`LOG_DIN_W-1:0] dropped; // Saturating
		logic [`LOG_DIN_W-1:0]             din;
	} status_t;

	// Frame fields, last declared field is word 0 and goes out first
	typedef struct packed {
		logic [`LOG_ADC_W-1:0]  diff;   // Word 5, adc0 - adc1
		logic [`LOG_ADC_W-1:0]  adc1;   // Word 4
		logic [`LOG_ADC_W-1:0]  adc0;   // Word 3
		status_t                status; // Word 2
		logic [`LOG_WORD_W-1:0] seq_hi; // Word 1
		logic [`LOG_WORD_W-1:0] seq_lo; // Word 0
	} frame_fields_t;

	// Filled through fields, sent out through words
	typedef union packed {
		logic [`LOG_FRAME_WORDS-1:0][`LOG_WORD_W-1:0] words;
		frame_fields_t                                 fields;
	} log_frame_u;

endpackage

// ==== rtl/ext_clk_conditioner.sv ====
// Reference clock pin conditioning
// Synchronizer chain and falling edge detector
// One clk1 cycle tick per falling edge of the pin

`timescale 1ns/1ps
`include "laser_log_params.svh"

module ext_clk_conditioner (
	input  logic clk1,
	input  logic arst_n,
	input  logic ext_clk_pin, // Asynchronous reference
	output logic ext_tick     // One cycle per falling edge
);

	localparam int SYNC = `LOG_EXT_SYNC;

	logic [SYNC-1:0] sync_q; // Oldest sample in the top bit
	logic            fall_q; // Edge seen between last two stages

	////////////////////////////////////////////////////////////////////////////
	// Sample the pin, detect high to low, register the detection again

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			sync_q   <= '0;
			fall_q   <= 1'b0;
			ext_tick <= 1'b0;
		end else begin
			sync_q   <= {sync_q[SYNC-2:0], ext_clk_pin}; // Shift in
			fall_q   <= sync_q[SYNC-1] & ~sync_q[SYNC-2]; // Was high, now low
			ext_tick <= fall_q;
		end
	end

	// A single edge never gives a two cycle tick
	a_tick_single : assert property (
		@(posedge clk1) disable iff (!arst_n)
		ext_tick |=> !ext_tick
	);

endmodule

// ==== rtl/frame_logger.sv ====
// Slow data logger frame producer
// Captures seq, status and ADC samples on each accepted tick
// Writes the frame word by word into the FIFO, word 0 first
// Counts ticks skipped while busy or short of FIFO room

`timescale 1ns/1ps
`include "laser_log_params.svh"

module frame_logger #(
	parameter int DEPTH = `LOG_FIFO_DEPTH // Must match the FIFO
) (
	input  logic                          clk1,
	input  logic                          arst_n,
	input  logic                          ext_tick,
	input  logic [`LOG_DIN_W-1:0]         din,
	input  laser_log_pkg::adc_sample_t    adc,
	input  logic [$clog2(DEPTH):0]        level,   // Words now in the FIFO
	output laser_log_pkg::fifo_wr_t       fifo_wr
);

	localparam int CNT_W  = $clog2(DEPTH) + 1;
	localparam int NWORDS = `LOG_FRAME_WORDS;
	localparam int IDX_W  = $clog2(NWORDS);
	localparam int DROP_W = `LOG_WORD_W - `LOG_DIN_W;

	logic [`LOG_DIN_W-1:0]     din_q;   // Registered inputs
	logic [2*`LOG_WORD_W-1:0]  seq;     // Written frames
	logic [DROP_W-1:0]         dropped; // Skipped ticks, saturating
	logic                      busy;    // Sending a frame
	logic [IDX_W-1:0]          idx;     // Word being sent
	logic                      room;    // Six free words in the FIFO
	logic                      start;
	logic                      skip;
	laser_log_pkg::log_frame_u frame_d;
	laser_log_pkg::log_frame_u frame_q;

	assign room  = (level <= CNT_W'(DEPTH - NWORDS));
	assign start = ext_tick & ~busy & room;
	assign skip  = ext_tick & ~start; // Busy or no room

	////////////////////////////////////////////////////////////////////////////
	// Frame contents at the tick

	always_comb begin
		frame_d.fields.seq_lo         = seq[`LOG_WORD_W-1:0];
		frame_d.fields.seq_hi         = seq[2*`LOG_WORD_W-1:`LOG_WORD_W];
		frame_d.fields.status.dropped = dropped;
		frame_d.fields.status.din     = din_q;
		frame_d.fields.adc0           = adc.adc0;
		frame_d.fields.adc1           = adc.adc1;
		frame_d.fields.diff           = adc.adc0 - adc.adc1; // Wraps to 16 bits
	end

	// Input register and frame latch, payload only
	always_ff @(posedge clk1) begin
		din_q <= din;
		if (start)
			frame_q <= frame_d;
	end

	////////////////////////////////////////////////////////////////////////////
	// Counters and word sequencer

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			seq     <= '0;
			dropped <= '0;
			busy    <= 1'b0;
			idx     <= '0;
		end else begin
			if (skip && dropped != '1)
				dropped <= dropped + 1'b1; // Stops at all ones
			if (start) begin
				seq  <= seq + 1'b1;
				busy <= 1'b1;
				idx  <= '0;
			end else if (busy) begin
				if (idx == IDX_W'(NWORDS - 1))
					busy <= 1'b0; // Last word goes out this cycle
				else
					idx <= idx + 1'b1;
			end
		end
	end

	// One word per busy cycle
	always_comb begin
		fifo_wr.wr   = busy;
		fifo_wr.data = frame_q.words[idx];
	end

	a_idx_range : assert property (
		@(posedge clk1) disable iff (!arst_n)
		busy |-> idx < IDX_W'(NWORDS)
	);

	// Frame start only with a full frame of room in the FIFO
	a_start_room : assert property (
		@(posedge clk1) disable iff (!arst_n)
		$rose(busy) |-> $past(level) <= CNT_W'(DEPTH - NWORDS)
	);

endmodule

// ==== rtl/word_fifo.sv ====
// Single clock word FIFO between logger and host pipe
// Show-ahead head word, fill level for the producer
// Circular memory with read and write pointers

`timescale 1ns/1ps
`include "laser_log_params.svh"

module word_fifo #(
	parameter int DEPTH = `LOG_FIFO_DEPTH // Power of two
) (
	input  logic                    clk1,
	input  logic                    arst_n,
	input  laser_log_pkg::fifo_wr_t fifo_wr,
	input  logic                    pop,   // Removes head this cycle
	output logic [`LOG_WORD_W-1:0]  head,  // Oldest word
	output logic                    empty,
	output logic [$clog2(DEPTH):0]  level  // Stored words
);

	localparam int AW    = $clog2(DEPTH);
	localparam int CNT_W = AW + 1;

	logic [`LOG_WORD_W-1:0] mem [DEPTH];
	logic [AW-1:0]          wr_ptr;
	logic [AW-1:0]          rd_ptr;
	logic [CNT_W-1:0]       count;
	logic                   full;
	logic                   push;
	logic                   pull;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign push  = fifo_wr.wr & ~full;
	assign pull  = pop & ~empty;
	assign level = count;
	assign head  = mem[rd_ptr]; // Show-ahead read

	////////////////////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk1) begin
		if (push)
			mem[wr_ptr] <= fifo_wr.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and fill count

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH
			if (pull)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pull})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or none
			endcase
		end
	end

	// Logger holds off until a whole frame fits
	a_no_write_full : assert property (
		@(posedge clk1) disable iff (!arst_n)
		fifo_wr.wr |-> !full
	);

	// Pipe port gates host reads with empty
	a_no_pop_empty : assert property (
		@(posedge clk1) disable iff (!arst_n)
		pop |-> !empty
	);

endmodule

// ==== rtl/host_pipe_port.sv ====
// Host side of the slow logger pipe
// Read strobe to FIFO pop, registered word with a valid pulse
// Sticky flag for reads that find the FIFO empty

`timescale 1ns/1ps
`include "laser_log_params.svh"

module host_pipe_port (
	input  logic                   clk1,
	input  logic                   arst_n,
	input  logic                   pipe_read,     // Host strobe
	input  logic [`LOG_WORD_W-1:0] head,          // FIFO head word
	input  logic                   empty,
	output logic                   pop,
	output logic [`LOG_WORD_W-1:0] pipe_data,
	output logic                   pipe_valid,    // One cycle per word
	output logic                   pipe_empty,
	output logic                   pipe_underrun  // Held until reset
);

	assign pop        = pipe_read & ~empty; // Only real words leave
	assign pipe_empty = empty;

	////////////////////////////////////////////////////////////////////////////
	// Output word, payload only

	always_ff @(posedge clk1) begin
		if (pop)
			pipe_data <= head;
	end

	////////////////////////////////////////////////////////////////////////////
	// Valid pulse and underrun flag

	always_ff @(posedge clk1 or negedge arst_n) begin
		if (!arst_n) begin
			pipe_valid    <= 1'b0;
			pipe_underrun <= 1'b0;
		end else begin
			pipe_valid <= pop; // Word one cycle after the strobe
			if (pipe_read && empty)
				pipe_underrun <= 1'b1;
		end
	end

endmodule

// ==== rtl/laser_log_top.sv ====
// Slow data logger top level
// Reference pin conditioner, frame logger, word FIFO, host pipe port

`timescale 1ns/1ps
`include "laser_log_params.svh"

module laser_log_top #(
	parameter int DEPTH = `LOG_FIFO_DEPTH
) (
	input  logic                       clk1,
	input  logic                       arst_n,
	input  logic                       ext_clk_pin,
	input  logic [`LOG_DIN_W-1:0]      din,
	input  laser_log_pkg::adc_sample_t adc,
	input  logic                       pipe_read,
	output logic [`LOG_WORD_W-1:0]     pipe_data,
	output logic                       pipe_valid,
	output logic                       pipe_empty,
	output logic                       pipe_underrun
);

	logic                    ext_tick;
	laser_log_pkg::fifo_wr_t fifo_wr;
	logic [$clog2(DEPTH):0]  level;
	logic [`LOG_WORD_W-1:0]  head;
	logic                    empty;
	logic                    pop;

	////////////////////////////////////////////////////////////////////////////
	// Producer side

	ext_clk_conditioner u_ext_clk (
		.clk1        (clk1),
		.arst_n      (arst_n),
		.ext_clk_pin (ext_clk_pin),
		.ext_tick    (ext_tick)
	);

	frame_logger #(.DEPTH(DEPTH)) u_logger (
		.clk1     (clk1),
		.arst_n   (arst_n),
		.ext_tick (ext_tick),
		.din      (din),
		.adc      (adc),
		.level    (level),
		.fifo_wr  (fifo_wr)
	);

	////////////////////////////////////////////////////////////////////////////
	// Buffer and host side

	word_fifo #(.DEPTH(DEPTH)) u_fifo (
		.clk1    (clk1),
		.arst_n  (arst_n),
		.fifo_wr (fifo_wr),
		.pop     (pop),
		.head    (head),
		.empty   (empty),
		.level   (level)
	);

	host_pipe_port u_pipe (
		.clk1          (clk1),
		.arst_n        (arst_n),
		.pipe_read     (pipe_read),
		.head          (head),
		.empty         (empty),
		.pop           (pop),
		.pipe_data     (pipe_data),
		.pipe_valid    (pipe_valid),
		.pipe_empty    (pipe_empty),
		.pipe_underrun (pipe_underrun)
	);

endmodule

// ==== verif/laser_log_tb.sv ====
// Testbench of the slow data logger
// Clock, reset, random reference periods and host reads from an LCG
// Frame model built from the values at each falling edge of the pin
// Word collector and frame checker on the host pipe

`timescale 1ns/1ps
`include "laser_log_params.svh"

module laser_log_tb;

	localparam int N_PERIODS  = 120;   // Period index fits the adc0 low byte
	localparam int READ_LIMIT = 40000; // Cycles for the whole read loop

	logic                       clk1 = 1'b0;
	logic                       arst_n;
	logic                       ext_clk_pin;
	logic [`LOG_DIN_W-1:0]      din;
	laser_log_pkg::adc_sample_t adc;
	logic                       pipe_read;
	logic [`LOG_WORD_W-1:0]     pipe_data;
	logic                       pipe_valid;
	logic                       pipe_empty;
	logic                       pipe_underrun;

	logic [31:0]            rng_state = 32'h55e4_aa9f;
	logic                   stim_done = 1'b0;
	int                     errors    = 0;
	int                     frames_rx = 0;
	int                     skipped   = 0;  // Periods with no frame so far
	int                     last_period = -1;
	int                     word_cnt  = 0;
	logic [`LOG_WORD_W-1:0] words [`LOG_FRAME_WORDS];

	// Model with one entry per reference period
	logic [`LOG_ADC_W-1:0] rec_adc0 [$];
	logic [`LOG_ADC_W-1:0] rec_adc1 [$];
	logic [`LOG_DIN_W-1:0] rec_din  [$];

	always #50 clk1 = ~clk1; // 100 ns period

	laser_log_top DUT (
		.clk1          (clk1),
		.arst_n        (arst_n),
		.ext_clk_pin   (ext_clk_pin),
		.din           (din),
		.adc           (adc),
		.pipe_read     (pipe_read),
		.pipe_data     (pipe_data),
		.pipe_valid    (pipe_valid),
		.pipe_empty    (pipe_empty),
		.pipe_underrun (pipe_underrun)
	);

	////////////////////////////////////////////////////////////////////////////
	// Random numbers, checks and end of run

	// LCG step returning the upper half since the low bits repeat quickly
	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d, frames checked: %0d, periods skipped: %0d",
			errors, frames_rx, skipped);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
		finish_run();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	// One reference period per loop with new inputs while the pin is high
	task automatic drive_periods();
		logic [15:0] r;
		int          hi_t;
		int          lo_t;
		for (int p = 0; p < N_PERIODS; p++) begin
			r        = next_rand();
			hi_t     = 10 + r[3:0];
			lo_t     = 10 + r[7:4];  // Tick and frame latch fall inside this
			din      = r[10:8];
			r        = next_rand();
			adc.adc0 = {r[15:8], 8'(p)}; // Period index in the low byte
			r        = next_rand();
			adc.adc1 = r;
			ext_clk_pin = 1'b1;
			repeat (hi_t) @(negedge clk1);
			ext_clk_pin = 1'b0;
			rec_din.push_back(din);       // Values at the falling edge
			rec_adc0.push_back(adc.adc0);
			rec_adc1.push_back(adc.adc1);
			repeat (lo_t) @(negedge clk1);
		end
		repeat (30) @(negedge clk1); // Let the last frame reach the FIFO
		stim_done = 1'b1;
	endtask

	// Host reads with short gaps and now and then a long one that fills the FIFO
	task automatic host_reads();
		logic [15:0] r;
		int          gap;
		int          idle;
		int          spent;
		idle  = 0;
		spent = 0;
		while (!(stim_done && idle >= 40)) begin
			@(negedge clk1);
			spent++;
			if (spent > READ_LIMIT)
				report_timeout("the FIFO to drain");
			if (pipe_empty) begin
				idle++;
			end else begin
				idle      = 0;
				pipe_read = 1'b1;
				@(negedge clk1);
				pipe_read = 1'b0;
				r = next_rand();
				if (!stim_done && r[7:2] == 6'd0)
					gap = 200 + r[15:8]; // Host stalls
				else
					gap = r[1:0];
				repeat (gap) @(negedge clk1);
				spent += gap + 1;
			end
		end
	endtask

	// Read on an empty FIFO gives no word but a sticky flag
	task automatic underrun_check();
		check_value("pipe_underrun", pipe_underrun, 1'b0);
		pipe_read = 1'b1;
		@(negedge clk1);
		pipe_read = 1'b0;
		check_value("pipe_valid", pipe_valid, 1'b0);
		check_value("pipe_underrun", pipe_underrun, 1'b1);
		repeat (5) begin
			@(negedge clk1);
			check_value("pipe_valid", pipe_valid, 1'b0);
			check_value("pipe_underrun", pipe_underrun, 1'b1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame collector and checker

	task automatic check_frame();
		int                    p;
		logic [`LOG_ADC_W-1:0] exp_diff;
		p = words[3][7:0];
		check_value("seq", {words[1], words[0]}, frames_rx); // Counts written frames
		if (p <= last_period || p >= rec_adc0.size()) begin
			errors++;
			$display("Frame %0d at %0t ns names period %0d, which is not after period %0d",
				frames_rx, $time, p, last_period);
		end else begin
			skipped += p - last_period - 1; // Gap since the previous frame
			check_value("status.dropped", words[2][15:3], skipped);
			check_value("status.din", words[2][2:0], rec_din[p]);
			check_value("adc0", words[3], rec_adc0[p]);
			check_value("adc1", words[4], rec_adc1[p]);
			exp_diff = rec_adc0[p] - rec_adc1[p]; // Wraps to 16 bits
			check_value("diff", words[5], exp_diff);
			last_period = p;
		end
		frames_rx++;
	endtask

	// Registered outputs are stable at the falling edge
	always @(negedge clk1) begin
		if (arst_n && pipe_valid) begin
			words[word_cnt] = pipe_data;
			word_cnt++;
			if (word_cnt == `LOG_FRAME_WORDS) begin
				check_frame();
				word_cnt = 0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		arst_n      = 1'b0;
		ext_clk_pin = 1'b0;
		din         = '0;
		adc         = '0;
		pipe_read   = 1'b0;
		repeat (8) @(negedge clk1);
		arst_n = 1'b1;
		@(negedge clk1);
		check_value("pipe_empty", pipe_empty, 1'b1);   // Idle outputs
		check_value("pipe_valid", pipe_valid, 1'b0);
		check_value("pipe_underrun", pipe_underrun, 1'b0);
		fork
			drive_periods();
			host_reads();
		join
		check_value("words of an unfinished frame", word_cnt, 0);
		if (frames_rx == 0) begin
			errors++;
			$display("No frame reached the host pipe");
		end
		underrun_check();
		finish_run();
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/laser_log_pkg.sv
rtl/ext_clk_conditioner.sv
rtl/frame_logger.sv
rtl/word_fifo.sv
rtl/host_pipe_port.sv
rtl/laser_log_top.sv
verif/laser_log_tb.sv

// ==== Bender.yml ====
package:
  name: laser_log

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/laser_log_pkg.sv
      - rtl/ext_clk_conditioner.sv
      - rtl/frame_logger.sv
      - rtl/word_fifo.sv
      - rtl/host_pipe_port.sv
      - rtl/laser_log_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/laser_log_tb.sv
